//--- rtl/l2_mshr_pkg.sv
`default_nettype none

package l2_mshr_pkg;

    // outstanding miss slots
    localparam int n_mshr = 4;
    localparam int mshr_bits = 2;

    // address split of a line address
    localparam int tag_bits = 8;
    localparam int set_bits = 4;

    // l2 associativity, 8 ways
    localparam int way_bits = 3;

    // line geometry
    localparam int words_per_line = 4;
    localparam int word_bits = 32;

    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [set_bits-1:0] set_t;
    typedef logic [way_bits-1:0] way_t;
    typedef logic [word_bits-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [words_per_line-1:0] line_t;

    // one bit per word of the line
    typedef logic [words_per_line-1:0] word_mask_t;

    // unstable states tracked by an entry
    // spx_i must stay zero, reset relies on it
    typedef enum logic [2:0] {
        spx_i  = 3'd0,
        spx_is = 3'd1,
        spx_im = 3'd2,
        spx_ii = 3'd3,
        spx_sm = 3'd4
    } mshr_state_e;

    // forwarded coherence messages from the llc
    typedef enum logic [1:0] {
        fwd_req_s = 2'd0,
        fwd_req_o = 2'd1,
        fwd_inv   = 2'd2
    } fwd_msg_e;

    // operations issued by the l2 fsm
    typedef enum logic [1:0] {
        mshr_idle     = 2'd0,
        mshr_lookup   = 2'd1,
        mshr_peek_req = 2'd2,
        mshr_peek_fwd = 2'd3
    } mshr_op_e;

    // line address as seen by the search
    typedef struct packed {
        tag_t tag;
        set_t set;
    } line_addr_t;

    // one outstanding miss, 150 bits
    typedef struct packed {
        mshr_state_e state;
        tag_t        tag;
        set_t        set;
        way_t        way;
        line_t       line;
        word_mask_t  word_mask;
    } mshr_entry_t;

    // write data for add and field updates
    // set is missing here, it comes from the address
    typedef struct packed {
        mshr_state_e state;
        tag_t        tag;
        way_t        way;
        line_t       line;
        word_mask_t  word_mask;
    } mshr_update_t;

endpackage

`default_nettype wire

//--- rtl/mshr_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_entry_array (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              add_entry,
    input  logic                              update_state,
    input  logic                              update_line,
    input  logic                              update_tag,
    input  logic                              update_word_mask,
    input  logic [l2_mshr_pkg::mshr_bits-1:0] idx,
    input  logic [l2_mshr_pkg::set_bits-1:0]  set,
    input  l2_mshr_pkg::mshr_update_t         upd,
    output l2_mshr_pkg::mshr_entry_t          entries [l2_mshr_pkg::n_mshr]
);
    import l2_mshr_pkg::*;

    // any single-field rewrite this cycle
    logic any_update;

    assign any_update = update_state | update_line | update_tag | update_word_mask;

    for (genvar i = 0; i < n_mshr; i++) begin : g_entry
        // slot addressed by the registered search index
        logic        sel;
        logic        add_en;
        logic        state_en;
        logic        line_en;
        logic        tag_en;
        logic        mask_en;
        mshr_state_e state_q;
        tag_t        tag_q;
        set_t        set_q;
        way_t        way_q;
        line_t       line_q;
        word_mask_t  mask_q;

        assign sel = (idx == mshr_bits'(i));

        // add rewrites every field, strobes only their own
        assign add_en   = sel & add_entry;
        assign state_en = sel & (add_entry | update_state);
        assign line_en  = sel & (add_entry | update_line);
        assign tag_en   = sel & (add_entry | update_tag);
        assign mask_en  = sel & (add_entry | update_word_mask);

        // set and way fixed for the life of the miss
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                set_q <= '0;
                way_q <= '0;
            end else if (add_en) begin
                set_q <= set;
                way_q <= upd.way;
            end
        end

        // state, spx_i frees the slot
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                state_q <= spx_i;
            end else if (state_en) begin
                state_q <= upd.state;
            end
        end

        // line data
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                line_q <= '0;
            end else if (line_en) begin
                line_q <= upd.line;
            end
        end

        // tag
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                tag_q <= '0;
            end else if (tag_en) begin
                tag_q <= upd.tag;
            end
        end

        // words still pending
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                mask_q <= '0;
            end else if (mask_en) begin
                mask_q <= upd.word_mask;
            end
        end

        assign entries[i] = '{
            state:     state_q,
            tag:       tag_q,
            set:       set_q,
            way:       way_q,
            line:      line_q,
            word_mask: mask_q
        };
    end

    // fsm must not mix an add with a field rewrite of the same slot
    a_no_update_on_add: assert property (
        @(posedge clk) disable iff (!rst)
        add_entry |-> !any_update
    ) else $error("field update strobe together with add_entry");

endmodule

`default_nettype wire

//--- rtl/mshr_search.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_search (
    input  logic                              clk,
    input  logic                              rst,
    input  l2_mshr_pkg::mshr_op_e             op,
    input  l2_mshr_pkg::line_addr_t           addr,
    input  l2_mshr_pkg::fwd_msg_e             fwd_msg,
    input  l2_mshr_pkg::mshr_entry_t          entries [l2_mshr_pkg::n_mshr],
    output logic                              set_conflict,
    output logic                              clr_set_conflict,
    output logic                              set_fwd_stall,
    output logic                              clr_fwd_stall,
    output logic                              hit_next,
    output logic [l2_mshr_pkg::mshr_bits-1:0] fwd_stall_entry,
    output logic [l2_mshr_pkg::mshr_bits-1:0] idx_next,
    output logic                              hit,
    output logic [l2_mshr_pkg::mshr_bits-1:0] idx
);
    import l2_mshr_pkg::*;

    // per-entry compare results
    logic [n_mshr-1:0]    valid_vec;
    logic [n_mshr-1:0]    match_vec;
    logic [n_mshr-1:0]    set_hit_vec;

    // reduced results, highest index wins
    logic                 match_any;
    logic                 set_any;
    logic [mshr_bits-1:0] match_idx;
    logic [mshr_bits-1:0] free_idx;
    mshr_state_e          win_state;
    logic                 fwd_exempt;

    // compare every slot against the address
    always_comb begin
        for (int i = 0; i < n_mshr; i++) begin
            valid_vec[i]   = (entries[i].state != spx_i);
            set_hit_vec[i] = valid_vec[i] && (entries[i].set == addr.set);
            match_vec[i]   = set_hit_vec[i] && (entries[i].tag == addr.tag);
        end
    end

    // later slots overwrite earlier ones
    always_comb begin
        match_idx = '0;
        free_idx  = '0;
        win_state = spx_i;
        for (int i = 0; i < n_mshr; i++) begin
            if (match_vec[i]) begin
                match_idx = mshr_bits'(i);
                win_state = entries[i].state;
            end
            if (!valid_vec[i]) begin
                free_idx = mshr_bits'(i);
            end
        end
    end

    assign match_any = |match_vec;
    assign set_any   = |set_hit_vec;

    // inv against a pending shared fill needs no stall
    // only the winning slot is looked at
    assign fwd_exempt = (fwd_msg == fwd_inv) && (win_state == spx_is);

    // opcode decode
    always_comb begin
        hit_next         = 1'b0;
        idx_next         = '0;
        set_conflict     = 1'b0;
        clr_set_conflict = 1'b0;
        set_fwd_stall    = 1'b0;
        clr_fwd_stall    = 1'b0;
        case (op)
            mshr_lookup: begin
                hit_next = match_any;
                idx_next = match_idx;
            end
            mshr_peek_req: begin
                // free slot for the next add, 0 if full
                idx_next         = free_idx;
                set_conflict     = set_any;
                clr_set_conflict = !set_any;
            end
            mshr_peek_fwd: begin
                hit_next      = match_any;
                idx_next      = match_idx;
                set_fwd_stall = match_any && !fwd_exempt;
                clr_fwd_stall = !(match_any && !fwd_exempt);
            end
            default: begin
                hit_next = 1'b0;
            end
        endcase
    end

    // entry to park the stalled forward on
    assign fwd_stall_entry = set_fwd_stall ? idx_next : '0;

    // idle keeps the last result for the fsm
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit <= 1'b0;
            idx <= '0;
        end else if (op != mshr_idle) begin
            hit <= hit_next;
            idx <= idx_next;
        end
    end

    // a forward is either stalled or released, never both
    a_fwd_stall_excl: assert property (
        @(posedge clk) disable iff (!rst)
        !(set_fwd_stall && clr_fwd_stall)
    ) else $error("set_fwd_stall and clr_fwd_stall both high");

    // conflict only reported while peeking a request
    a_conflict_op: assert property (
        @(posedge clk) disable iff (!rst)
        set_conflict |-> (op == mshr_peek_req)
    ) else $error("set_conflict outside peek_req");

endmodule

`default_nettype wire

//--- rtl/l2_mshr.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mshr (
    input  logic                              clk,
    input  logic                              rst,

    // write strobes from the l2 fsm
    input  logic                              add_entry,
    input  logic                              update_state,
    input  logic                              update_line,
    input  logic                              update_tag,
    input  logic                              update_word_mask,

    // search request
    input  l2_mshr_pkg::mshr_op_e             op,
    input  l2_mshr_pkg::line_addr_t           addr,
    input  l2_mshr_pkg::mshr_update_t         upd,
    input  l2_mshr_pkg::fwd_msg_e             fwd_msg,

    // stored entries
    output l2_mshr_pkg::mshr_entry_t          entries [l2_mshr_pkg::n_mshr],

    // same-cycle search results
    output logic                              set_conflict,
    output logic                              clr_set_conflict,
    output logic                              set_fwd_stall,
    output logic                              clr_fwd_stall,
    output logic [l2_mshr_pkg::mshr_bits-1:0] fwd_stall_entry,
    output logic                              hit_next,
    output logic [l2_mshr_pkg::mshr_bits-1:0] idx_next,

    // results registered one cycle later
    output logic                              hit,
    output logic [l2_mshr_pkg::mshr_bits-1:0] idx
);

    // storage, written at the registered index
    // set of a new entry taken from the request address
    mshr_entry_array i_mshr_entry_array (
        .clk              (clk),
        .rst              (rst),
        .add_entry        (add_entry),
        .update_state     (update_state),
        .update_line      (update_line),
        .update_tag       (update_tag),
        .update_word_mask (update_word_mask),
        .idx              (idx),
        .set              (addr.set),
        .upd              (upd),
        .entries          (entries)
    );

    // lookup, peek and forward stall decision
    mshr_search i_mshr_search (
        .clk              (clk),
        .rst              (rst),
        .op               (op),
        .addr             (addr),
        .fwd_msg          (fwd_msg),
        .entries          (entries),
        .set_conflict     (set_conflict),
        .clr_set_conflict (clr_set_conflict),
        .set_fwd_stall    (set_fwd_stall),
        .clr_fwd_stall    (clr_fwd_stall),
        .hit_next         (hit_next),
        .fwd_stall_entry  (fwd_stall_entry),
        .idx_next         (idx_next),
        .hit              (hit),
        .idx              (idx)
    );

endmodule

`default_nettype wire

//--- dv/l2_mshr_model.svh
`ifndef l2_mshr_model_svh
`define l2_mshr_model_svh

// expected results of one search
typedef struct packed {
    logic                 hit_next;
    logic [mshr_bits-1:0] idx_next;
    logic                 set_conflict;
    logic                 clr_set_conflict;
    logic                 set_fwd_stall;
    logic                 clr_fwd_stall;
    logic [mshr_bits-1:0] fwd_stall_entry;
} search_exp_t;

// model copy of the slots and the registered result
mshr_entry_t          model_entries [n_mshr];
logic                 model_hit;
logic [mshr_bits-1:0] model_idx;

task automatic model_reset();
    for (int i = 0; i < n_mshr; i++) begin
        model_entries[i] = '0;
    end
    model_hit = 1'b0;
    model_idx = '0;
endtask

// search rules applied to the model slots
function automatic search_exp_t predict(mshr_op_e o, line_addr_t a, fwd_msg_e f);
    search_exp_t r;
    int          win;
    int          free_slot;
    logic        conflict;
    logic        exempt;
    r         = '0;
    win       = -1;
    free_slot = -1;
    conflict  = 1'b0;
    // walk down, first hit found is the highest index
    for (int i = n_mshr - 1; i >= 0; i--) begin
        if (model_entries[i].state != spx_i) begin
            if (model_entries[i].set == a.set)
                conflict = 1'b1;
            if (win < 0 && model_entries[i].set == a.set && model_entries[i].tag == a.tag)
                win = i;
        end else if (free_slot < 0) begin
            free_slot = i;
        end
    end
    // inv against a shared fill in flight goes through
    exempt = (win >= 0) && (f == fwd_inv) && (model_entries[win].state == spx_is);
    if (o == mshr_lookup || o == mshr_peek_fwd) begin
        r.hit_next = (win >= 0);
        r.idx_next = (win >= 0) ? mshr_bits'(win) : '0;
    end
    if (o == mshr_peek_req) begin
        r.idx_next         = (free_slot >= 0) ? mshr_bits'(free_slot) : '0;
        r.set_conflict     = conflict;
        r.clr_set_conflict = !conflict;
    end
    if (o == mshr_peek_fwd) begin
        r.set_fwd_stall   = (win >= 0) && !exempt;
        r.clr_fwd_stall   = !r.set_fwd_stall;
        r.fwd_stall_entry = r.set_fwd_stall ? r.idx_next : '0;
    end
    return r;
endfunction

// one clock edge, strobes are {add, state, line, tag, mask}
task automatic model_step(mshr_op_e o, line_addr_t a, fwd_msg_e f, logic [4:0] strb,
                          mshr_update_t u);
    search_exp_t p;
    p = predict(o, a, f);
    if (strb[4]) begin
        model_entries[model_idx] = '{state: u.state, tag: u.tag, set: a.set, way: u.way,
                                     line: u.line, word_mask: u.word_mask};
    end
    if (strb[3])
        model_entries[model_idx].state = u.state;
    if (strb[2])
        model_entries[model_idx].line = u.line;
    if (strb[1])
        model_entries[model_idx].tag = u.tag;
    if (strb[0])
        model_entries[model_idx].word_mask = u.word_mask;
    // idle keeps the last result
    if (o != mshr_idle) begin
        model_hit = p.hit_next;
        model_idx = p.idx_next;
    end
endtask

`endif

//--- dv/l2_mshr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mshr_tb;
    import l2_mshr_pkg::*;

    localparam int reset_cycles   = 4;
    localparam int num_directed   = 12;
    localparam int num_random     = 1000;
    localparam int timeout_cycles = 2 * (reset_cycles + num_directed + num_random);

    // strobe vectors {add, state, line, tag, mask}
    localparam logic [4:0] st_none  = 5'b00000;
    localparam logic [4:0] st_add   = 5'b10000;
    localparam logic [4:0] st_state = 5'b01000;

    localparam line_addr_t addr_a = '{tag: 8'h5a, set: 4'h3};
    localparam line_addr_t addr_b = '{tag: 8'h21, set: 4'h3};

    typedef logic [$bits(mshr_entry_t)-1:0] cmp_t;

    logic                 clk;
    logic                 rst;
    logic                 add_entry;
    logic                 update_state;
    logic                 update_line;
    logic                 update_tag;
    logic                 update_word_mask;
    mshr_op_e             op;
    line_addr_t           addr;
    mshr_update_t         upd;
    fwd_msg_e             fwd_msg;
    mshr_entry_t          entries [n_mshr];
    logic                 set_conflict;
    logic                 clr_set_conflict;
    logic                 set_fwd_stall;
    logic                 clr_fwd_stall;
    logic [mshr_bits-1:0] fwd_stall_entry;
    logic                 hit_next;
    logic [mshr_bits-1:0] idx_next;
    logic                 hit;
    logic [mshr_bits-1:0] idx;

    int seed;
    int cycle_count = 0;
    // how often the random mix reached the interesting cases
    int hits_seen   = 0;
    int confl_seen  = 0;
    int stalls_seen = 0;
    int exempt_seen = 0;

    `include "l2_mshr_model.svh"

    l2_mshr i_l2_mshr (
        .clk(clk), .rst(rst), .add_entry(add_entry), .update_state(update_state),
        .update_line(update_line), .update_tag(update_tag),
        .update_word_mask(update_word_mask), .op(op), .addr(addr), .upd(upd),
        .fwd_msg(fwd_msg), .entries(entries), .set_conflict(set_conflict),
        .clr_set_conflict(clr_set_conflict), .set_fwd_stall(set_fwd_stall),
        .clr_fwd_stall(clr_fwd_stall), .fwd_stall_entry(fwd_stall_entry),
        .hit_next(hit_next), .idx_next(idx_next), .hit(hit), .idx(idx)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    task automatic compare(string name, cmp_t got, cmp_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0d ns %s is %0h, expected %0h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // every output against the model at mid-cycle
    task automatic check_all();
        search_exp_t e;
        e = predict(op, addr, fwd_msg);
        for (int i = 0; i < n_mshr; i++) begin
            compare($sformatf("entries[%0d]", i), cmp_t'(entries[i]), cmp_t'(model_entries[i]));
        end
        compare("hit", cmp_t'(hit), cmp_t'(model_hit));
        compare("idx", cmp_t'(idx), cmp_t'(model_idx));
        compare("hit_next", cmp_t'(hit_next), cmp_t'(e.hit_next));
        compare("idx_next", cmp_t'(idx_next), cmp_t'(e.idx_next));
        compare("set_conflict", cmp_t'(set_conflict), cmp_t'(e.set_conflict));
        compare("clr_set_conflict", cmp_t'(clr_set_conflict), cmp_t'(e.clr_set_conflict));
        compare("set_fwd_stall", cmp_t'(set_fwd_stall), cmp_t'(e.set_fwd_stall));
        compare("clr_fwd_stall", cmp_t'(clr_fwd_stall), cmp_t'(e.clr_fwd_stall));
        compare("fwd_stall_entry", cmp_t'(fwd_stall_entry), cmp_t'(e.fwd_stall_entry));
        hits_seen   += int'(e.hit_next);
        confl_seen  += int'(e.set_conflict);
        stalls_seen += int'(e.set_fwd_stall);
        exempt_seen += int'(op == mshr_peek_fwd && e.hit_next && !e.set_fwd_stall);
    endtask

    // model takes the edge before new inputs go out
    task automatic run_cycle(mshr_op_e o, line_addr_t a, fwd_msg_e f, logic [4:0] strb,
                             mshr_update_t u);
        @(posedge clk);
        model_step(op, addr, fwd_msg,
                   {add_entry, update_state, update_line, update_tag, update_word_mask}, upd);
        op               <= o;
        addr             <= a;
        fwd_msg          <= f;
        upd              <= u;
        add_entry        <= strb[4];
        update_state     <= strb[3];
        update_line      <= strb[2];
        update_tag       <= strb[1];
        update_word_mask <= strb[0];
        @(negedge clk);
        check_all();
    endtask

    function automatic mshr_update_t make_upd(mshr_state_e s, tag_t t);
        return '{state: s, tag: t, way: 3'd5, line: {4{32'hc0de_0000}} ^ {4{t, t, t, t}},
                 word_mask: 4'hf};
    endfunction

    task automatic run_random();
        logic [31:0]  r1;
        logic [31:0]  r2;
        line_addr_t   a;
        mshr_update_t u;
        logic [4:0]   strb;
        r1 = $random(seed);
        r2 = $random(seed);
        // two tags over four sets keeps hits and conflicts common
        a.tag       = tag_t'(r1[0]);
        a.set       = set_t'(r1[3:2]);
        u.state     = mshr_state_e'(3'(r1[7:4] % 4'd5));
        u.tag       = tag_t'(r2[0]);
        u.way       = r2[3:1];
        u.line      = {r2, ~r1, r1, r1 ^ r2};
        u.word_mask = r2[7:4];
        // at most one strobe per cycle
        strb = (r1[10:8] < 3'd5) ? (st_add >> r1[10:8]) : st_none;
        run_cycle(mshr_op_e'(r1[12:11]), a,
                  (r1[14:13] == 2'd3) ? fwd_inv : fwd_msg_e'(r1[14:13]), strb, u);
    endtask

    initial begin
        seed             = 32'h653b_b45b;
        rst              <= 1'b0;
        add_entry        <= 1'b0;
        update_state     <= 1'b0;
        update_line      <= 1'b0;
        update_tag       <= 1'b0;
        update_word_mask <= 1'b0;
        op               <= mshr_idle;
        addr             <= '0;
        upd              <= '0;
        fwd_msg          <= fwd_req_s;
        model_reset();
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_all();
        // fill free slot 3 as spx_is and search it
        run_cycle(mshr_peek_req, addr_a, fwd_req_s, st_none, '0);
        run_cycle(mshr_idle, addr_a, fwd_req_s, st_add, make_upd(spx_is, addr_a.tag));
        run_cycle(mshr_lookup, addr_a, fwd_req_s, st_none, '0);
        run_cycle(mshr_peek_fwd, addr_a, fwd_inv, st_none, '0);
        run_cycle(mshr_peek_fwd, addr_a, fwd_req_o, st_none, '0);
        // highest index wins once a second slot holds the same line
        run_cycle(mshr_peek_req, addr_a, fwd_req_s, st_none, '0);
        run_cycle(mshr_idle, addr_a, fwd_req_s, st_add, make_upd(spx_im, addr_a.tag));
        run_cycle(mshr_lookup, addr_a, fwd_req_s, st_none, '0);
        // release slot 3 through a state rewrite
        run_cycle(mshr_idle, addr_a, fwd_req_s, st_state, make_upd(spx_i, addr_a.tag));
        run_cycle(mshr_lookup, addr_a, fwd_req_s, st_none, '0);
        run_cycle(mshr_peek_fwd, addr_a, fwd_inv, st_none, '0);
        run_cycle(mshr_peek_fwd, addr_b, fwd_inv, st_none, '0);
        // only the random mix counts toward the case tally
        hits_seen   = 0;
        confl_seen  = 0;
        stalls_seen = 0;
        exempt_seen = 0;
        repeat (num_random) run_random();
        if (hits_seen == 0 || confl_seen == 0 || stalls_seen == 0 || exempt_seen == 0) begin
            $display("stimulus never produced a hit, a conflict, a stall or an exemption");
            $display("*** TEST FAILED ***");
            $fatal(1, "coverage hole");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- l2_mshr.f
+incdir+dv
rtl/l2_mshr_pkg.sv
rtl/mshr_entry_array.sv
rtl/mshr_search.sv
rtl/l2_mshr.sv
dv/l2_mshr_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the l2_mshr testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f l2_mshr.f \
    --top-module l2_mshr_tb -o l2_mshr_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/l2_mshr_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi
